// File: project.f
+incdir+tb
hdl/replica_pkg.sv
hdl/ring_if.sv
hdl/random.sv
hdl/anneal_regs.sv
hdl/sub_node.sv
hdl/node.sv
hdl/anneal_top.sv
tb/tb_anneal.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_anneal \
    -f project.f -o tb_anneal
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_anneal)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1

// File: tb/tb_tasks.svh
// testbench copy of the distance matrix
distance_data_t dis_model  [city_num][city_num];
total_data_t    init_total [replica_num];   // totals right after the first init
int             test_errors = 0;            // error count when the current test began

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("mismatch in %s: expected %0d, actual %0d", name, expected, actual);
        errors++;
    end
endtask

task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
endtask

function automatic total_data_t tour_len(input tour_t t);
    int sum;
    sum = 0;
    for (int i = 0; i < city_num; i++) begin
        sum += int'(dis_model[t[i]][t[(i + 1) % city_num]]);   // closing edge wraps
    end
    return total_data_t'(sum);
endfunction

// length of the tour 0, 1, ..., city_num-1
function automatic total_data_t identity_len();
    int sum;
    sum = 0;
    for (int i = 0; i < city_num; i++) begin
        sum += int'(dis_model[i][(i + 1) % city_num]);
    end
    return total_data_t'(sum);
endfunction

function automatic logic [city_num-1:0] city_mask(input tour_t t);
    logic [city_num-1:0] mask;
    mask = '0;
    for (int i = 0; i < city_num; i++) begin
        mask[t[i]] = 1'b1;
    end
    return mask;
endfunction

task automatic write_distance(input city_t a, input city_t b, input distance_data_t d);
    cfg_dis_write = 1'b1;
    cfg_dis_waddr = {a, b};
    cfg_dis_wdata = d;
    @(negedge clk);
    cfg_dis_write = 1'b0;
    dis_model[a][b] = d;
endtask

task automatic write_threshold(input int n, input logic [7:0] v);
    cfg_thr_write = 1'b1;
    cfg_thr_node  = node_w'(n);
    cfg_thr_wdata = v;
    @(negedge clk);
    cfg_thr_write = 1'b0;
endtask

task automatic load_random_matrix();
    distance_data_t d;
    for (int i = 0; i < city_num; i++) begin
        for (int j = 0; j <= i; j++) begin
            d = (i == j) ? 8'd0 : distance_data_t'(1 + $urandom % 100);
            write_distance(city_t'(i), city_t'(j), d);
            if (i != j) begin
                write_distance(city_t'(j), city_t'(i), d);   // both halves
            end
        end
    end
endtask

task automatic pulse_init(output int busy_cycles);
    init = 1'b1;
    @(negedge clk);
    init = 1'b0;
    busy_cycles = 0;
    while (busy) begin
        busy_cycles++;
        @(negedge clk);
    end
endtask

task automatic run_opt(input string name, input int run_cycles);
    int elapsed;
    int step_cycles;
    opt_run     = 1'b1;
    elapsed     = 0;
    step_cycles = 0;
    @(negedge clk);
    elapsed++;
    while (busy && elapsed < run_cycles) begin
        step_cycles++;
        @(negedge clk);
        elapsed++;
    end
    // every node starts its first step on the same edge
    check_value({name, " step cycles"}, 32'd6, 32'(step_cycles));
    repeat (run_cycles - elapsed) @(negedge clk);
    opt_run = 1'b0;
    while (busy) begin
        @(negedge clk);         // let the current steps finish
    end
endtask

task automatic read_node(input int n, output tour_t t, output total_data_t total,
                         output logic [7:0] thr);
    rd_node = node_w'(n);
    for (int p = 0; p < city_num; p++) begin
        rd_pos = city_t'(p);
        @(negedge clk);
        t[p] = rd_city;
    end
    total = rd_total;
    thr   = rd_thr;
endtask

task automatic check_identity(input string name, input tour_t t);
    for (int p = 0; p < city_num; p++) begin
        check_value({name, " tour"}, 32'(p), 32'(t[p]));
    end
endtask

// tour must be a permutation and the total must match its length
task automatic check_route(input string name, input int n, output total_data_t total);
    tour_t      t;
    logic [7:0] thr;
    read_node(n, t, total, thr);
    check_value({name, " permutation"}, 32'hff, 32'(city_mask(t)));
    check_value({name, " total"}, 32'(tour_len(t)), 32'(total));
endtask

task automatic reset_and_init();
    tour_t       t;
    total_data_t total;
    logic [7:0]  thr;
    int          busy_cycles;
    check_value("reset_and_init busy", 32'd0, 32'(busy));
    for (int n = 0; n < replica_num; n++) begin
        read_node(n, t, total, thr);
        check_value("reset_and_init thr", 32'd0, 32'(thr));
        check_value("reset_and_init reset total", 32'd0, 32'(total));
        check_identity("reset_and_init reset", t);
    end
    load_random_matrix();
    pulse_init(busy_cycles);
    check_value("reset_and_init busy cycles", 32'(city_num + 1), 32'(busy_cycles));
    for (int n = 0; n < replica_num; n++) begin
        read_node(n, t, total, thr);
        check_identity("reset_and_init", t);
        check_value("reset_and_init total", 32'(identity_len()), 32'(total));
        init_total[n] = total;
    end
    end_test("reset_and_init");
endtask

task automatic greedy_optimisation();
    total_data_t total;
    for (int n = 0; n < replica_num; n++) begin
        write_threshold(n, 8'd0);
    end
    run_opt("greedy_optimisation", 300);
    for (int n = 0; n < replica_num; n++) begin
        check_route("greedy_optimisation", n, total);
        if (total > init_total[n]) begin
            $display("greedy_optimisation: node %0d total rose from %0d to %0d",
                     n, init_total[n], total);
            errors++;
        end
    end
    end_test("greedy_optimisation");
endtask

task automatic hot_optimisation();
    total_data_t total;
    for (int n = 0; n < replica_num; n++) begin
        write_threshold(n, 8'd255);
    end
    run_opt("hot_optimisation", 300);
    for (int n = 0; n < replica_num; n++) begin
        check_route("hot_optimisation", n, total);
    end
    end_test("hot_optimisation");
endtask

task automatic replica_exchange();
    tour_t       rec_tour  [replica_num];
    total_data_t rec_total [replica_num];
    tour_t       t;
    total_data_t total;
    tour_t       tmp_tour;
    total_data_t tmp_total;
    logic [7:0]  thr;
    for (int n = 0; n < replica_num; n++) begin
        read_node(n, rec_tour[n], rec_total[n], thr);
    end
    for (int phase = 0; phase < 2; phase++) begin
        exchange_phase = 1'(phase);
        exchange_run   = 1'b1;
        @(negedge clk);
        exchange_run   = 1'b0;      // swap lands on the edge just passed
        check_value("replica_exchange busy", 32'd0, 32'(busy));
        for (int k = phase; k + 1 < replica_num; k += 2) begin
            if (rec_total[k + 1] < rec_total[k]) begin
                tmp_tour         = rec_tour[k];
                tmp_total        = rec_total[k];
                rec_tour[k]      = rec_tour[k + 1];
                rec_total[k]     = rec_total[k + 1];
                rec_tour[k + 1]  = tmp_tour;
                rec_total[k + 1] = tmp_total;
            end
        end
        for (int n = 0; n < replica_num; n++) begin
            read_node(n, t, total, thr);
            check_value("replica_exchange total", 32'(rec_total[n]), 32'(total));
            check_value("replica_exchange tour", 32'(rec_tour[n]), 32'(t));
        end
    end
    end_test("replica_exchange");
endtask

task automatic reconfigure();
    distance_data_t d;
    tour_t          t;
    total_data_t    total;
    logic [7:0]     thr;
    int             busy_cycles;
    d = dis_model[2][3] + 8'd50;        // edge 2-3 lies on the identity tour
    write_distance(city_t'(2), city_t'(3), d);
    write_distance(city_t'(3), city_t'(2), d);
    for (int n = 0; n < replica_num; n++) begin
        write_threshold(n, 8'(17 * n + 5));
    end
    pulse_init(busy_cycles);
    for (int n = 0; n < replica_num; n++) begin
        read_node(n, t, total, thr);
        check_identity("reconfigure", t);
        check_value("reconfigure total", 32'(identity_len()), 32'(total));
        check_value("reconfigure thr", 32'(17 * n + 5), 32'(thr));
    end
    end_test("reconfigure");
endtask

// File: tb/tb_anneal.sv
`timescale 1ns/100ps

module tb_anneal
    import replica_pkg::*;
();

localparam int replica_num   = 4;
localparam int node_w        = $clog2(replica_num);
localparam int clk_period    = 100;
localparam int timeout_limit = 20000;   // tests need roughly 1100 cycles

logic              clk;
logic              rst_n;
logic              cfg_dis_write;
logic [5:0]        cfg_dis_waddr;
distance_data_t    cfg_dis_wdata;
logic              cfg_thr_write;
logic [node_w-1:0] cfg_thr_node;
logic [7:0]        cfg_thr_wdata;
logic              init;
logic              opt_run;
logic              exchange_run;
logic              exchange_phase;
logic [node_w-1:0] rd_node;
city_t             rd_pos;
logic              busy;
city_t             rd_city;
total_data_t       rd_total;
logic [7:0]        rd_thr;

int cycles       = 0;
int errors       = 0;
int tests_run    = 0;
int tests_failed = 0;
int seed_val;

`include "tb_tasks.svh"

anneal_top #(.replica_num(replica_num)) i_dut
(
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .cfg_dis_write  ( cfg_dis_write  ),
    .cfg_dis_waddr  ( cfg_dis_waddr  ),
    .cfg_dis_wdata  ( cfg_dis_wdata  ),
    .cfg_thr_write  ( cfg_thr_write  ),
    .cfg_thr_node   ( cfg_thr_node   ),
    .cfg_thr_wdata  ( cfg_thr_wdata  ),
    .init           ( init           ),
    .opt_run        ( opt_run        ),
    .exchange_run   ( exchange_run   ),
    .exchange_phase ( exchange_phase ),
    .rd_node        ( rd_node        ),
    .rd_pos         ( rd_pos         ),
    .busy           ( busy           ),
    .rd_city        ( rd_city        ),
    .rd_total       ( rd_total       ),
    .rd_thr         ( rd_thr         )
);

initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
end

// hard stop in case the DUT never settles
always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
        $display("timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("Test failures found");
        $finish;
    end
end

initial begin
    seed_val       = $urandom(32'h79b6a70a);
    rst_n          = 1'b0;
    cfg_dis_write  = 1'b0;
    cfg_dis_waddr  = '0;
    cfg_dis_wdata  = '0;
    cfg_thr_write  = 1'b0;
    cfg_thr_node   = '0;
    cfg_thr_wdata  = '0;
    init           = 1'b0;
    opt_run        = 1'b0;
    exchange_run   = 1'b0;
    exchange_phase = 1'b0;
    rd_node        = '0;
    rd_pos         = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    reset_and_init();
    greedy_optimisation();
    hot_optimisation();
    replica_exchange();
    reconfigure();

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule

// File: hdl/anneal_top.sv
`timescale 1ns/100ps

module anneal_top
    import replica_pkg::*;
#(
    parameter int replica_num = 4
)
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_dis_write,
    input  logic [city_num_log*2-1:0]      cfg_dis_waddr,
    input  distance_data_t                 cfg_dis_wdata,
    input  logic                           cfg_thr_write,
    input  logic [$clog2(replica_num)-1:0] cfg_thr_node,
    input  logic [7:0]                     cfg_thr_wdata,
    input  logic                           init,
    input  logic                           opt_run,
    input  logic                           exchange_run,
    input  logic                           exchange_phase,
    input  logic [$clog2(replica_num)-1:0] rd_node,
    input  city_t                          rd_pos,
    output logic                           busy,
    output city_t                          rd_city,
    output total_data_t                    rd_total,
    output logic [7:0]                     rd_thr
);

city_t                  dist_a [replica_num];
city_t                  dist_b [replica_num];
distance_data_t         dist_q [replica_num];
logic [7:0]             thr    [replica_num];
tour_t                  tour   [replica_num];
total_data_t            total  [replica_num];
logic [replica_num-1:0] node_busy;
logic                   exchange_go;

// link k sits between node k-1 and node k, both ends are dummies
ring_if link [replica_num+1] ();

assign link[0].lo_total           = '0;
assign link[0].lo_tour            = '0;
assign link[0].swap               = 1'b0;
assign link[replica_num].hi_total = '1;     // never shorter, top node never swaps up
assign link[replica_num].hi_tour  = identity_tour();

assign busy        = |node_busy;
assign exchange_go = exchange_run & ~busy;  // exchange only between settled nodes

anneal_regs #(.replica_num(replica_num)) regs
(
    .clk       ( clk           ),
    .rst_n     ( rst_n         ),
    .dis_write ( cfg_dis_write ),
    .dis_waddr ( cfg_dis_waddr ),
    .dis_wdata ( cfg_dis_wdata ),
    .thr_write ( cfg_thr_write ),
    .thr_node  ( cfg_thr_node  ),
    .thr_wdata ( cfg_thr_wdata ),
    .dist_a    ( dist_a        ),
    .dist_b    ( dist_b        ),
    .dist_q    ( dist_q        ),
    .thr       ( thr           )
);

genvar k;
generate
    for (k = 0; k < replica_num; k++) begin : gen_node
        node #(.id(k)) replica
        (
            .clk            ( clk            ),
            .rst_n          ( rst_n          ),
            .init           ( init           ),
            .opt_run        ( opt_run        ),
            .exchange_run   ( exchange_go    ),
            .exchange_phase ( exchange_phase ),
            .thr            ( thr[k]         ),
            .dist_q         ( dist_q[k]      ),
            .dist_a         ( dist_a[k]      ),
            .dist_b         ( dist_b[k]      ),
            .busy           ( node_busy[k]   ),
            .tour           ( tour[k]        ),
            .total          ( total[k]       ),
            .up             ( link[k+1]      ),
            .down           ( link[k]        )
        );
    end
endgenerate

// readout
assign rd_city  = tour[rd_node][rd_pos];
assign rd_total = total[rd_node];
assign rd_thr   = thr[rd_node];

endmodule

// File: hdl/node.sv
`timescale 1ns/100ps

module node
    import replica_pkg::*;
#(
    parameter int id = 0
)
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           init,
    input  logic           opt_run,
    input  logic           exchange_run,
    input  logic           exchange_phase,
    input  logic [7:0]     thr,
    input  distance_data_t dist_q,
    output city_t          dist_a,
    output city_t          dist_b,
    output logic           busy,
    output tour_t          tour,
    output total_data_t    total,
    ring_if.lower          up,          // pair with node id+1
    ring_if.upper          down         // pair with node id-1
);

localparam logic my_phase = 1'(id % 2);

city_t       pos;
logic [7:0]  accept_byte;
logic        start;
logic        pair_sel;
logic        load;
tour_t       load_tour;
total_data_t load_total;

assign start    = opt_run & ~busy;
assign pair_sel = exchange_run && (exchange_phase == my_phase);

assign up.lo_total   = total;
assign up.lo_tour    = tour;
assign up.swap       = pair_sel && (up.hi_total < total);  // hotter side has the shorter tour
assign down.hi_total = total;
assign down.hi_tour  = tour;

// only one of the two links can swap in a given phase
assign load       = up.swap | down.swap;
assign load_tour  = up.swap ? up.hi_tour  : down.lo_tour;
assign load_total = up.swap ? up.hi_total : down.lo_total;

random random
(
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .run         ( busy        ),
    .id_seed     ( 64'(id)     ),
    .pos         ( pos         ),
    .accept_byte ( accept_byte )
);

sub_node opt_node
(
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .init        ( init        ),
    .start       ( start       ),
    .pos         ( pos         ),
    .accept_byte ( accept_byte ),
    .thr         ( thr         ),
    .dist_q      ( dist_q      ),
    .load        ( load        ),
    .load_tour   ( load_tour   ),
    .load_total  ( load_total  ),
    .dist_a      ( dist_a      ),
    .dist_b      ( dist_b      ),
    .busy        ( busy        ),
    .tour        ( tour        ),
    .total       ( total       )
);

endmodule

// File: hdl/sub_node.sv
`timescale 1ns/100ps

module sub_node
    import replica_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           init,
    input  logic           start,
    input  city_t          pos,
    input  logic [7:0]     accept_byte,
    input  logic [7:0]     thr,
    input  distance_data_t dist_q,
    input  logic           load,
    input  tour_t          load_tour,
    input  total_data_t    load_total,
    output city_t          dist_a,
    output city_t          dist_b,
    output logic           busy,
    output tour_t          tour,
    output total_data_t    total
);

localparam logic [2:0] s_idle   = 3'd0;
localparam logic [2:0] s_init   = 3'd1;
localparam logic [2:0] s_read   = 3'd2;
localparam logic [2:0] s_decide = 3'd3;
localparam logic [2:0] s_update = 3'd4;

logic [2:0]            state;
logic [city_num_log:0] cnt;         // init edge index or read slot
city_t                 p;           // swap positions p and p+1
city_t                 city_a;
city_t                 city_b;
city_t                 city_c;
city_t                 city_d;
logic signed [9:0]     delta;       // new edges minus old edges
logic                  take;

assign busy = (state != s_idle);

// cities around the swapped pair, positions wrap mod city_num
assign city_a = tour[city_t'(p - city_t'(1))];
assign city_b = tour[p];
assign city_c = tour[city_t'(p + city_t'(1))];
assign city_d = tour[city_t'(p + city_t'(2))];

always_comb begin
    dist_a = city_a;
    dist_b = city_b;
    if (state == s_init) begin
        dist_a = tour[cnt[city_num_log-1:0]];
        dist_b = tour[city_t'(cnt[city_num_log-1:0] + city_t'(1))];
    end else begin
        case (cnt[1:0])
            2'd1: begin
                dist_a = city_c;    // old edge c-d
                dist_b = city_d;
            end
            2'd2: begin
                dist_a = city_a;    // new edge a-c
                dist_b = city_c;
            end
            2'd3: begin
                dist_a = city_b;    // new edge b-d
                dist_b = city_d;
            end
            default: ;              // old edge a-b
        endcase
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= s_idle;
        cnt   <= '0;
        tour  <= identity_tour();
        total <= '0;
    end else begin
        case (state)
            s_idle: begin
                cnt <= '0;
                if (load) begin                 // replica exchange wins
                    tour  <= load_tour;
                    total <= load_total;
                end else if (init) begin
                    tour  <= identity_tour();
                    total <= '0;
                    state <= s_init;
                end else if (start) begin
                    state <= s_read;
                end
            end
            s_init: begin
                if (cnt == (city_num_log+1)'(city_num)) begin
                    state <= s_idle;            // one trailing cycle after the sum
                end else begin
                    total <= total + total_data_t'(dist_q);
                    cnt   <= cnt + 1'b1;
                end
            end
            s_read: begin
                cnt <= cnt + 1'b1;
                if (cnt[1:0] == 2'd3) begin
                    state <= s_decide;
                end
            end
            s_decide: begin
                state <= s_update;
            end
            s_update: begin
                if (take) begin
                    tour[p]                        <= city_c;
                    tour[city_t'(p + city_t'(1))]  <= city_b;
                    total <= total + total_data_t'(delta);  // sign-extends
                end
                state <= s_idle;
            end
            default: begin
                state <= s_idle;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == s_idle && start) begin
        p     <= pos;
        delta <= '0;
    end
    if (state == s_read) begin
        if (cnt[1]) begin
            delta <= delta + $signed({2'b00, dist_q});
        end else begin
            delta <= delta - $signed({2'b00, dist_q});
        end
    end
    if (state == s_decide) begin
        take <= (delta <= 10'sd0) || (accept_byte < thr);
    end
end

// exchanges from either neighbour must wait for an idle node
a_load_idle : assert property (@(posedge clk) disable iff (!rst_n) load |-> !busy);

endmodule

// File: hdl/anneal_regs.sv
`timescale 1ns/100ps

module anneal_regs
    import replica_pkg::*;
#(
    parameter int replica_num = 4
)
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           dis_write,
    input  logic [city_num_log*2-1:0]      dis_waddr,     // {from city, to city}
    input  distance_data_t                 dis_wdata,
    input  logic                           thr_write,
    input  logic [$clog2(replica_num)-1:0] thr_node,
    input  logic [7:0]                     thr_wdata,
    input  city_t                          dist_a [replica_num],
    input  city_t                          dist_b [replica_num],
    output distance_data_t                 dist_q [replica_num],
    output logic [7:0]                     thr    [replica_num]
);

distance_data_t dis_mem [city_num*city_num];

always_ff @(posedge clk) begin
    if (dis_write) begin
        dis_mem[dis_waddr] <= dis_wdata;
    end
end

// per-node acceptance thresholds
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int n = 0; n < replica_num; n++) begin
            thr[n] <= '0;
        end
    end else if (thr_write) begin
        thr[thr_node] <= thr_wdata;
    end
end

// one independent read port per node
always_comb begin
    for (int n = 0; n < replica_num; n++) begin
        dist_q[n] = dis_mem[{dist_a[n], dist_b[n]}];
    end
end

a_thr_node_range : assert property (@(posedge clk) disable iff (!rst_n)
    thr_write |-> (int'(thr_node) < replica_num));

endmodule

// File: hdl/random.sv
`timescale 1ns/100ps

module random
    import replica_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic [63:0] id_seed,
    output city_t       pos,
    output logic [7:0]  accept_byte
);

localparam logic [63:0] xorshift_seed = 64'h2545_f491_4f6c_dd1d;
localparam logic [63:0] seed_mul      = 64'h9e37_79b9_7f4a_7c15;   // spreads small ids

logic [63:0] state;
logic [63:0] state_next;
logic [63:0] mix_0;
logic [63:0] mix_1;

// xorshift64, shifts 13 / 7 / 17
always_comb begin
    mix_0      = state ^ (state << 13);
    mix_1      = mix_0 ^ (mix_0 >> 7);
    state_next = mix_1 ^ (mix_1 << 17);
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= xorshift_seed ^ (id_seed * seed_mul);
    end else if (run) begin
        state <= state_next;
    end
end

assign pos         = state[63 -: city_num_log];     // top bits for the position
assign accept_byte = state[39:32];

// a zero state would lock the generator for good
a_state_nonzero : assert property (@(posedge clk) disable iff (!rst_n) state != '0);

endmodule

// File: hdl/ring_if.sv
`timescale 1ns/100ps

interface ring_if
    import replica_pkg::*;
();

    total_data_t lo_total;      // from node k
    tour_t       lo_tour;
    total_data_t hi_total;      // from node k+1
    tour_t       hi_tour;
    logic        swap;          // exchange strobe, decided in node k

    modport lower (
        output lo_total,
        output lo_tour,
        output swap,
        input  hi_total,
        input  hi_tour
    );

    modport upper (
        output hi_total,
        output hi_tour,
        input  lo_total,
        input  lo_tour,
        input  swap
    );

endinterface

// File: hdl/replica_pkg.sv
package replica_pkg;

    localparam int city_num     = 8;
    localparam int city_num_log = 3;    // city_num is a power of two, index math wraps

    typedef logic [city_num_log-1:0] city_t;

    typedef logic [7:0] distance_data_t;

    // 8 edges of at most 255 each
    typedef logic [11:0] total_data_t;

    // element i holds the city visited at tour position i
    typedef city_t [city_num-1:0] tour_t;

    function automatic tour_t identity_tour();
        tour_t t;
        for (int i = 0; i < city_num; i++) begin
            t[i] = city_t'(i);
        end
        return t;
    endfunction

endpackage
